//--- hdl/loc_tx_types_pkg.sv
`default_nettype none

package loc_tx_types_pkg;

  localparam int SAMPLE_W = 16; // one I or Q word
  localparam int PHASE_W  = 24; // tone phase accumulator

  // one complex output sample
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_sample_t;

  typedef enum logic [1:0] {
    ST_SETTLE = 2'b00, // tone generator start-up wait
    ST_SYNC   = 2'b01, // bpsk preamble, marker raised
    ST_IDLE   = 2'b10, // gap, output not valid
    ST_SWEEP  = 2'b11  // stepped frequency hops
  } tx_state_t;

endpackage

`default_nettype wire

//--- hdl/loc_tx_cfg_pkg.sv
`default_nettype none

package loc_tx_cfg_pkg;

  // register addresses on the config port
  typedef enum logic [2:0] {
    CFG_START_INC = 3'd0,
    CFG_HOP_STEP  = 3'd1,
    CFG_HOP_COUNT = 3'd2,
    CFG_HOP_LEN   = 3'd3,
    CFG_IDLE_LEN  = 3'd4
  } cfg_addr_t;

  typedef struct packed {
    logic [loc_tx_types_pkg::PHASE_W-1:0] start_inc; // increment of the first hop
    logic [loc_tx_types_pkg::PHASE_W-1:0] hop_step;  // added per hop
    logic [7:0]                           hop_count;
    logic [15:0]                          hop_len;   // samples per hop
    logic [15:0]                          idle_len;
  } loc_cfg_t;

  localparam logic [loc_tx_types_pkg::PHASE_W-1:0] CFG_DEF_START_INC = 24'h100000;
  localparam logic [loc_tx_types_pkg::PHASE_W-1:0] CFG_DEF_HOP_STEP  = 24'h040000;
  localparam logic [7:0]                           CFG_DEF_HOP_COUNT = 8'd4;
  localparam logic [15:0]                          CFG_DEF_HOP_LEN   = 16'd16;
  localparam logic [15:0]                          CFG_DEF_IDLE_LEN  = 16'd8;

endpackage

`default_nettype wire

//--- hdl/loc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module loc_cfg_regs (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         cfg_we,
  input  wire loc_tx_cfg_pkg::cfg_addr_t              cfg_addr,
  input  wire [loc_tx_types_pkg::PHASE_W-1:0]         cfg_wdata,
  output loc_tx_cfg_pkg::loc_cfg_t                    cfg
);

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.start_inc <= loc_tx_cfg_pkg::CFG_DEF_START_INC;
      cfg.hop_step  <= loc_tx_cfg_pkg::CFG_DEF_HOP_STEP;
      cfg.hop_count <= loc_tx_cfg_pkg::CFG_DEF_HOP_COUNT;
      cfg.hop_len   <= loc_tx_cfg_pkg::CFG_DEF_HOP_LEN;
      cfg.idle_len  <= loc_tx_cfg_pkg::CFG_DEF_IDLE_LEN;
    end else if (cfg_we) begin
      case (cfg_addr)
        loc_tx_cfg_pkg::CFG_START_INC: begin
          cfg.start_inc <= cfg_wdata;
        end
        loc_tx_cfg_pkg::CFG_HOP_STEP: begin
          cfg.hop_step <= cfg_wdata;
        end
        loc_tx_cfg_pkg::CFG_HOP_COUNT: begin
          cfg.hop_count <= cfg_wdata[7:0]; // low byte only
        end
        loc_tx_cfg_pkg::CFG_HOP_LEN: begin
          cfg.hop_len <= cfg_wdata[15:0];
        end
        loc_tx_cfg_pkg::CFG_IDLE_LEN: begin
          cfg.idle_len <= cfg_wdata[15:0];
        end
        default: begin
        end
      endcase
    end
  end

  // a zero hop count or length would stall the sweep forever
  a_hop_nonzero: assert property (@(posedge clk) disable iff (reset)
    cfg_we |=> cfg.hop_count != 8'd0 && cfg.hop_len != 16'd0);

endmodule

`default_nettype wire

//--- hdl/preamble_gen.sv
`timescale 1ns/1ps
`default_nettype none

module preamble_gen #(
  parameter int PRMB_OS   = 4,
  parameter int PRMB_BITS = 31,
  parameter int AMP       = 16384
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          prmb_start,
  output loc_tx_types_pkg::iq_sample_t prmb_sample,
  output logic                         prmb_done
);

  localparam int SW    = loc_tx_types_pkg::SAMPLE_W;
  localparam int OS_W  = $clog2(PRMB_OS + 1);
  localparam int BIT_W = $clog2(PRMB_BITS + 1);
  localparam logic signed [SW-1:0] AMP_P = SW'(AMP);
  localparam logic signed [SW-1:0] AMP_N = SW'(-AMP);

  logic [4:0]              lfsr;
  logic [OS_W-1:0]         os_cnt;  // cycles spent on the current bit
  logic [BIT_W-1:0]        bit_cnt;
  logic                    active;
  logic                    os_last;
  logic                    bit_last;
  logic signed [SW-1:0]    bpsk;

  assign os_last   = os_cnt == OS_W'(PRMB_OS - 1);
  assign bit_last  = bit_cnt == BIT_W'(PRMB_BITS - 1);
  assign prmb_done = active && os_last && bit_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr    <= 5'b00001;
      os_cnt  <= '0;
      bit_cnt <= '0;
      active  <= 1'b0;
    end else if (prmb_start) begin
      lfsr    <= 5'b00001; // seed
      os_cnt  <= '0;
      bit_cnt <= '0;
      active  <= 1'b1;
    end else if (active) begin
      if (os_last) begin
        os_cnt  <= '0;
        bit_cnt <= bit_cnt + 1'b1;
        lfsr    <= {lfsr[3:0], lfsr[4] ^ lfsr[2]}; // x^5+x^3+1, taps 5 and 3
        if (bit_last) begin
          active <= 1'b0;
        end
      end else begin
        os_cnt <= os_cnt + 1'b1;
      end
    end
  end

  assign bpsk        = lfsr[0] ? AMP_P : AMP_N;
  assign prmb_sample = {bpsk, bpsk}; // i equals q

  a_no_restart: assert property (@(posedge clk) disable iff (reset)
    prmb_start |-> !active);

endmodule

`default_nettype wire

//--- hdl/hop_tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module hop_tone_gen #(
  parameter int AMP = 16384
) (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           sweep_start,
  input  wire loc_tx_cfg_pkg::loc_cfg_t cfg,
  output loc_tx_types_pkg::iq_sample_t  tone_sample,
  output logic                          sweep_done
);

  localparam int SW = loc_tx_types_pkg::SAMPLE_W;
  localparam int PW = loc_tx_types_pkg::PHASE_W;
  localparam logic signed [SW-1:0] AMP_P = SW'(AMP);
  localparam logic signed [SW-1:0] AMP_N = SW'(-AMP);

  logic [PW-1:0] phase; // phase before this sample's add
  logic [PW-1:0] inc;
  logic [15:0]   samp_cnt;
  logic [7:0]    hop_cnt;
  logic          active;
  logic          samp_last;
  logic          hop_last;
  logic          p1;
  logic          p0;

  assign samp_last  = samp_cnt == cfg.hop_len - 16'd1;
  assign hop_last   = hop_cnt == cfg.hop_count - 8'd1;
  assign sweep_done = active && samp_last && hop_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      samp_cnt <= '0;
      hop_cnt  <= '0;
    end else if (sweep_start) begin
      active   <= 1'b1;
      samp_cnt <= '0;
      hop_cnt  <= '0;
    end else if (active) begin
      if (samp_last) begin
        samp_cnt <= '0;
        hop_cnt  <= hop_cnt + 8'd1;
        if (hop_last) begin
          active <= 1'b0;
        end
      end else begin
        samp_cnt <= samp_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_start) begin
      phase <= '0;
      inc   <= cfg.start_inc;
    end else if (active) begin
      phase <= phase + inc;
      if (samp_last) begin
        inc <= inc + cfg.hop_step; // next hop, higher frequency
      end
    end
  end

  // quadrant mapper on the two phase msbs
  assign p1 = phase[PW-1];
  assign p0 = phase[PW-2];
  assign tone_sample.i = (p1 == p0) ? AMP_P : AMP_N;
  assign tone_sample.q = p1 ? AMP_N : AMP_P;

endmodule

`default_nettype wire

//--- hdl/loc_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module loc_tx_ctrl #(
  parameter int SETTLE_LEN = 4
) (
  input  wire                               clk,
  input  wire                               reset,
  input  wire loc_tx_cfg_pkg::loc_cfg_t     cfg,
  input  wire loc_tx_types_pkg::iq_sample_t prmb_sample,
  input  wire                               prmb_done,
  input  wire loc_tx_types_pkg::iq_sample_t tone_sample,
  input  wire                               sweep_done,
  output logic                              prmb_start,
  output logic                              sweep_start,
  output loc_tx_types_pkg::iq_sample_t      tx_sample,
  output logic                              tx_valid,
  output logic                              sync_marker,
  output loc_tx_types_pkg::tx_state_t       frame_state
);

  loc_tx_types_pkg::tx_state_t  state;
  logic [15:0]                  cnt; // shared by settle and idle
  logic                         settle_last;
  logic                         idle_last;
  loc_tx_types_pkg::iq_sample_t sel;

  assign settle_last = cnt == 16'(SETTLE_LEN);
  assign idle_last   = cnt == cfg.idle_len - 16'd1;
  // generators restart on the edge that enters their phase
  assign prmb_start  = state == loc_tx_types_pkg::ST_SETTLE && settle_last;
  assign sweep_start = state == loc_tx_types_pkg::ST_IDLE && idle_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= loc_tx_types_pkg::ST_SETTLE;
      cnt   <= '0;
    end else begin
      case (state)
        loc_tx_types_pkg::ST_SETTLE: begin
          cnt <= settle_last ? 16'd0 : cnt + 16'd1;
          if (settle_last) begin
            state <= loc_tx_types_pkg::ST_SYNC;
          end
        end
        loc_tx_types_pkg::ST_SYNC: begin
          if (prmb_done) begin
            state <= loc_tx_types_pkg::ST_IDLE;
          end
        end
        loc_tx_types_pkg::ST_IDLE: begin
          cnt <= idle_last ? 16'd0 : cnt + 16'd1;
          if (idle_last) begin
            state <= loc_tx_types_pkg::ST_SWEEP;
          end
        end
        default: begin
          if (sweep_done) begin
            state <= loc_tx_types_pkg::ST_SETTLE; // frame repeats
          end
        end
      endcase
    end
  end

  always_comb begin
    case (state)
      loc_tx_types_pkg::ST_SYNC:  sel = prmb_sample;
      loc_tx_types_pkg::ST_SWEEP: sel = tone_sample;
      default:                    sel = '0; // silent in settle and idle
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid    <= 1'b0;
      sync_marker <= 1'b0;
      frame_state <= loc_tx_types_pkg::ST_SETTLE;
    end else begin
      tx_valid    <= state != loc_tx_types_pkg::ST_IDLE;
      sync_marker <= state == loc_tx_types_pkg::ST_SYNC;
      frame_state <= state;
    end
  end

  always_ff @(posedge clk) begin
    tx_sample <= sel;
  end

  a_prmb_done_in_sync: assert property (@(posedge clk) disable iff (reset)
    prmb_done |-> state == loc_tx_types_pkg::ST_SYNC);
  a_done_in_sweep: assert property (@(posedge clk) disable iff (reset)
    sweep_done |-> state == loc_tx_types_pkg::ST_SWEEP);

endmodule

`default_nettype wire

//--- hdl/loc_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module loc_tx_top #(
  parameter int SETTLE_LEN = 4,
  parameter int PRMB_OS    = 4,
  parameter int PRMB_BITS  = 31, // lfsr period limits this to 31
  parameter int AMP        = 16384
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 cfg_we,
  input  wire loc_tx_cfg_pkg::cfg_addr_t      cfg_addr,
  input  wire [loc_tx_types_pkg::PHASE_W-1:0] cfg_wdata,
  output loc_tx_types_pkg::iq_sample_t        tx_sample,
  output logic                                tx_valid,
  output logic                                sync_marker,
  output loc_tx_types_pkg::tx_state_t         frame_state
);

  loc_tx_cfg_pkg::loc_cfg_t     cfg;
  loc_tx_types_pkg::iq_sample_t prmb_sample;
  loc_tx_types_pkg::iq_sample_t tone_sample;
  logic                         prmb_start;
  logic                         prmb_done;
  logic                         sweep_start;
  logic                         sweep_done;

  loc_cfg_regs cfg_regs0 (.clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg(cfg));

  loc_tx_ctrl #(.SETTLE_LEN(SETTLE_LEN)) ctrl0 (.clk(clk), .reset(reset), .cfg(cfg),
    .prmb_sample(prmb_sample), .prmb_done(prmb_done), .tone_sample(tone_sample),
    .sweep_done(sweep_done), .prmb_start(prmb_start), .sweep_start(sweep_start),
    .tx_sample(tx_sample), .tx_valid(tx_valid), .sync_marker(sync_marker),
    .frame_state(frame_state));

  preamble_gen #(.PRMB_OS(PRMB_OS), .PRMB_BITS(PRMB_BITS), .AMP(AMP)) prmb0 (.clk(clk),
    .reset(reset), .prmb_start(prmb_start), .prmb_sample(prmb_sample), .prmb_done(prmb_done));

  hop_tone_gen #(.AMP(AMP)) tone0 (.clk(clk), .reset(reset), .sweep_start(sweep_start),
    .cfg(cfg), .tone_sample(tone_sample), .sweep_done(sweep_done));

endmodule

`default_nettype wire

//--- sim/loc_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module loc_tx_tb;

  localparam int SETTLE_LEN = 4;
  localparam int PRMB_OS    = 4;
  localparam int PRMB_BITS  = 31;
  localparam int AMP        = 16384;
  localparam int SW         = loc_tx_types_pkg::SAMPLE_W;
  localparam int PW         = loc_tx_types_pkg::PHASE_W;
  localparam logic signed [SW-1:0] AMP_P = SW'(AMP);
  localparam logic signed [SW-1:0] AMP_N = SW'(-AMP);

  logic                         clk = 1'b0;
  logic                         reset;
  logic                         cfg_we;
  loc_tx_cfg_pkg::cfg_addr_t    cfg_addr;
  logic [PW-1:0]                cfg_wdata;
  loc_tx_types_pkg::iq_sample_t tx_sample;
  logic                         tx_valid;
  logic                         sync_marker;
  loc_tx_types_pkg::tx_state_t  frame_state;

  logic [31:0] stim [0:63]; // {op, addr, data} per record
  int          cycle_cnt;
  int          cycle_limit = 64; // raised by each run record
  int          sample_err, state_err, flag_err, other_err;
  integer      seed = 59477;

  // reference model, for the cycle now in progress
  loc_tx_cfg_pkg::loc_cfg_t     m_cfg;
  loc_tx_types_pkg::tx_state_t  m_state;
  int                           m_cnt; // cycles done in this state
  int                           m_valid;
  int                           m_frames;
  int                           want_valid;
  logic [4:0]                   m_lfsr;
  logic [PW-1:0]                m_phase;
  logic [PW-1:0]                m_inc;
  // outputs due after the next edge
  loc_tx_types_pkg::iq_sample_t exp_sample;
  loc_tx_types_pkg::tx_state_t  exp_state;
  logic                         exp_valid;
  logic                         exp_marker;

  loc_tx_top #(.SETTLE_LEN(SETTLE_LEN), .PRMB_OS(PRMB_OS), .PRMB_BITS(PRMB_BITS), .AMP(AMP))
    dut0 (.clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .tx_sample(tx_sample), .tx_valid(tx_valid), .sync_marker(sync_marker),
    .frame_state(frame_state));

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: frames did not complete within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_sample(input loc_tx_types_pkg::iq_sample_t got,
                              input loc_tx_types_pkg::iq_sample_t want);
    if (got !== want) begin
      sample_err++;
      $display("ERROR tx_sample: expected %h, got %h at cycle %0d", want, got, cycle_cnt);
    end
  endtask

  task automatic check_state(input loc_tx_types_pkg::tx_state_t got,
                             input loc_tx_types_pkg::tx_state_t want);
    if (got !== want) begin
      state_err++;
      $display("ERROR frame_state: expected %h, got %h at cycle %0d", want, got, cycle_cnt);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      flag_err++;
      $display("ERROR %s: expected %h, got %h at cycle %0d", name, want, got, cycle_cnt);
    end
  endtask

  // compare the registered outputs, then move the model one clock on
  task automatic model_cycle();
    check_sample(tx_sample, exp_sample);
    check_state(frame_state, exp_state);
    check_bit("tx_valid", tx_valid, exp_valid);
    check_bit("sync_marker", sync_marker, exp_marker);
    exp_state  = m_state;
    exp_valid  = m_state != loc_tx_types_pkg::ST_IDLE;
    exp_marker = m_state == loc_tx_types_pkg::ST_SYNC;
    exp_sample = '0;
    if (m_state == loc_tx_types_pkg::ST_SYNC) begin
      exp_sample.i = m_lfsr[0] ? AMP_P : AMP_N;
      exp_sample.q = exp_sample.i;
    end else if (m_state == loc_tx_types_pkg::ST_SWEEP) begin
      exp_sample.i = (m_phase[PW-1] == m_phase[PW-2]) ? AMP_P : AMP_N;
      exp_sample.q = m_phase[PW-1] ? AMP_N : AMP_P;
    end
    if (exp_valid) begin
      m_valid++;
    end
    m_cnt++;
    case (m_state)
      loc_tx_types_pkg::ST_SETTLE: begin
        if (m_cnt == SETTLE_LEN + 1) begin
          m_state = loc_tx_types_pkg::ST_SYNC;
          m_cnt   = 0;
          m_lfsr  = 5'b00001;
        end
      end
      loc_tx_types_pkg::ST_SYNC: begin
        if (m_cnt % PRMB_OS == 0) begin
          m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]}; // x^5+x^3+1
        end
        if (m_cnt == PRMB_BITS * PRMB_OS) begin
          m_state = loc_tx_types_pkg::ST_IDLE;
          m_cnt   = 0;
        end
      end
      loc_tx_types_pkg::ST_IDLE: begin
        if (m_cnt == int'(m_cfg.idle_len)) begin
          m_state = loc_tx_types_pkg::ST_SWEEP;
          m_cnt   = 0;
          m_phase = '0;
          m_inc   = m_cfg.start_inc;
        end
      end
      default: begin
        m_phase = m_phase + m_inc;
        if (m_cnt % int'(m_cfg.hop_len) == 0) begin
          m_inc = m_inc + m_cfg.hop_step; // next hop
        end
        if (m_cnt == int'(m_cfg.hop_count) * int'(m_cfg.hop_len)) begin
          m_state = loc_tx_types_pkg::ST_SETTLE;
          m_cnt   = 0;
          if (m_valid != want_valid) begin
            other_err++;
            $display("ERROR valid_per_frame: expected %h, got %h", want_valid, m_valid);
          end
          m_valid = 0;
          m_frames++;
        end
      end
    endcase
    if (cfg_we) begin // a write lands after this edge
      case (cfg_addr)
        loc_tx_cfg_pkg::CFG_START_INC: m_cfg.start_inc = cfg_wdata;
        loc_tx_cfg_pkg::CFG_HOP_STEP:  m_cfg.hop_step = cfg_wdata;
        loc_tx_cfg_pkg::CFG_HOP_COUNT: m_cfg.hop_count = cfg_wdata[7:0];
        loc_tx_cfg_pkg::CFG_HOP_LEN:   m_cfg.hop_len = cfg_wdata[15:0];
        loc_tx_cfg_pkg::CFG_IDLE_LEN:  m_cfg.idle_len = cfg_wdata[15:0];
        default: ;
      endcase
    end
  endtask

  task automatic step_cycle(input logic we, input loc_tx_cfg_pkg::cfg_addr_t addr,
                            input logic [PW-1:0] data);
    @(negedge clk);
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = data;
    model_cycle();
  endtask

  task automatic apply_reset();
    reset  = 1'b1;
    cfg_we = 1'b0;
    repeat (3) @(negedge clk);
    reset           = 1'b0;
    m_cfg.start_inc = loc_tx_cfg_pkg::CFG_DEF_START_INC;
    m_cfg.hop_step  = loc_tx_cfg_pkg::CFG_DEF_HOP_STEP;
    m_cfg.hop_count = loc_tx_cfg_pkg::CFG_DEF_HOP_COUNT;
    m_cfg.hop_len   = loc_tx_cfg_pkg::CFG_DEF_HOP_LEN;
    m_cfg.idle_len  = loc_tx_cfg_pkg::CFG_DEF_IDLE_LEN;
    m_state         = loc_tx_types_pkg::ST_SETTLE;
    m_cnt           = 0;
    m_valid         = 0;
    exp_sample      = '0;
    exp_state       = loc_tx_types_pkg::ST_SETTLE;
    exp_valid       = 1'b0;
    exp_marker      = 1'b0;
    model_cycle(); // outputs still hold their reset values
  endtask

  task automatic run_frames(input int frames, input int valid_per_frame);
    want_valid  = valid_per_frame;
    m_frames    = 0;
    cycle_limit = cycle_cnt + frames * (valid_per_frame + int'(m_cfg.idle_len)) + 64;
    while (m_frames < frames) begin
      step_cycle(1'b0, loc_tx_cfg_pkg::CFG_START_INC, '0);
    end
    step_cycle(1'b0, loc_tx_cfg_pkg::CFG_START_INC, '0); // last sweep sample
  endtask

  initial begin
    int   idx;
    logic need_reset;
    reset     = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = loc_tx_cfg_pkg::CFG_START_INC;
    cfg_wdata = '0;
    for (int n = 0; n < 64; n++) begin
      stim[n] = '0;
    end
    $readmemh("sim/loc_tx_stimulus.txt", stim);
    if (stim[0] == 32'h0) begin
      other_err++;
      $display("stimulus file is missing or holds no records");
    end
    idx        = 0;
    need_reset = 1'b1;
    while (idx < 64 && stim[idx][31:28] != 4'h0) begin
      if (need_reset) begin
        apply_reset();
        need_reset = 1'b0;
      end
      case (stim[idx][31:28])
        4'h1: step_cycle(1'b1, loc_tx_cfg_pkg::cfg_addr_t'(stim[idx][26:24]), stim[idx][23:0]);
        4'h2: step_cycle(1'b1, loc_tx_cfg_pkg::cfg_addr_t'(stim[idx][26:24]), 24'($random(seed)));
        4'h3: begin
          run_frames(int'(stim[idx][7:0]), int'(stim[idx][23:8]));
          need_reset = 1'b1;
        end
        default: begin
          other_err++;
          $display("unknown opcode in stimulus record %0d", idx);
        end
      endcase
      idx++;
    end
    $display("errors: tx_sample %0d, frame_state %0d, valid/marker %0d, other %0d",
             sample_err, state_err, flag_err, other_err);
    if (sample_err + state_err + flag_err + other_err == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/loc_tx_stimulus.txt
// one record per word: {op[3:0], addr[3:0], data[23:0]}, op 0 ends the list
// op 1 write data, op 2 write random data, op 3 run: data[23:8] valid/frame, data[7:0] frames
// default config, two frames
3000C102
// written idle gap of 20
14000014
3000C101
// random start increment and hop step
20000000
21000000
3000C102
// three hops of 10 samples from a fixed start increment
102AAAAA
12000003
1300000A
30009F02
// five hops of 7 samples with a short idle gap
12000005
13000007
14000003
3000A401
00000000

//--- loc_tx.f
hdl/loc_tx_types_pkg.sv
hdl/loc_tx_cfg_pkg.sv
hdl/loc_cfg_regs.sv
hdl/preamble_gen.sv
hdl/hop_tone_gen.sv
hdl/loc_tx_ctrl.sv
hdl/loc_tx_top.sv
sim/loc_tx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module loc_tx_tb -f loc_tx.f -o loc_tx_sim \
  && ./obj_dir/loc_tx_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
